// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f compile.f --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
+incdir+include
src/cpu_pkg.sv
src/reg_file.sv
src/host_loader.sv
src/instr_mem.sv
src/data_mem.sv
src/cpu_core.sv
src/cpu_top.sv
test/tb_cpu.sv

// File: src/cpu_core.sv
////////////////////////////////////////////////////////////////////////////
// multi-cycle core
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          run,
    input  logic [cpu_pkg::data_w-1:0]    instr,
    input  logic [cpu_pkg::data_w-1:0]    dm_rdata,
    input  logic                          store_ready,
    output logic [cpu_pkg::mem_idx_w-1:0] fetch_idx,
    output logic                          dm_we,
    output logic                          dm_re,
    output logic [cpu_pkg::mem_idx_w-1:0] dm_idx,
    output logic [cpu_pkg::data_w-1:0]    dm_wdata,
    output logic                          store_valid,
    output logic [15:0]                   store_addr,
    output logic [cpu_pkg::data_w-1:0]    store_data,
    output logic                          halted
);

    typedef enum logic [2:0] {FETCH, EXEC, MEM_WB, HOST_WAIT, HALTED} seq_t;

    seq_t                          state, next_state;
    logic [15:0]                   pc;
    logic                          zf, nf;
    cpu_pkg::opcode_t              op;
    logic [cpu_pkg::reg_idx_w-1:0] rd, rs, rt;
    logic [cpu_pkg::data_w-1:0]    imm_ext;
    logic [cpu_pkg::data_w-1:0]    rs_data, rt_data;
    logic [cpu_pkg::data_w-1:0]    alu_b, alu_res;
    logic [15:0]                   eff_addr;
    logic                          use_imm, is_arith, to_host, taken;
    logic                          rf_we;
    logic [cpu_pkg::data_w-1:0]    rf_wdata;

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////
    assign op      = cpu_pkg::opcode_t'(instr[cpu_pkg::op_hi:cpu_pkg::op_lo]);
    assign rd      = instr[cpu_pkg::rd_hi:cpu_pkg::rd_lo];
    assign rs      = instr[cpu_pkg::rs_hi:cpu_pkg::rs_lo];
    assign rt      = instr[cpu_pkg::rt_hi:cpu_pkg::rt_lo];
    assign imm_ext = {{(cpu_pkg::data_w - 16){instr[cpu_pkg::imm_hi]}},
                      instr[cpu_pkg::imm_hi:cpu_pkg::imm_lo]};

    assign use_imm  = (op == cpu_pkg::ADDI) || (op == cpu_pkg::LD) || (op == cpu_pkg::ST);
    assign is_arith = (op == cpu_pkg::ADD) || (op == cpu_pkg::SUB) || (op == cpu_pkg::ADDI);

    // one adder serves arithmetic and address generation
    assign alu_b    = use_imm ? imm_ext : rt_data;
    assign alu_res  = (op == cpu_pkg::SUB) ? rs_data - alu_b : rs_data + alu_b;
    assign eff_addr = alu_res[15:0];
    assign to_host  = (op == cpu_pkg::ST) && (eff_addr >= cpu_pkg::host_win_base);

    always_comb begin
        case (op)
            cpu_pkg::BEQ: taken = zf;
            cpu_pkg::BNE: taken = !zf;
            cpu_pkg::BLT: taken = nf;
            cpu_pkg::JMP: taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    // ST reads its source through the rt port
    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_sel  (rs),
        .rt_sel  ((op == cpu_pkg::ST) ? rd : rt),
        .wr_sel  (rd),
        .wr_en   (rf_we),
        .wr_data (rf_wdata),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    assign rf_we    = (state == EXEC && is_arith) || (state == MEM_WB);
    assign rf_wdata = (state == MEM_WB) ? dm_rdata : alu_res;

    ////////////////////////////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            FETCH: if (run) next_state = EXEC;
            EXEC: begin
                if (op == cpu_pkg::HALT)
                    next_state = HALTED;
                else if (op == cpu_pkg::LD)
                    next_state = MEM_WB;
                else if (to_host)
                    next_state = HOST_WAIT;
                else
                    next_state = FETCH;
            end
            MEM_WB:    next_state = FETCH;
            HOST_WAIT: if (store_ready) next_state = FETCH;
            default:   next_state = HALTED;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FETCH;
            pc    <= '0;
            zf    <= 1'b0;
            nf    <= 1'b0;
        end else begin
            state <= next_state;
            if (!run)
                pc <= '0;
            else if (state == EXEC && op != cpu_pkg::HALT)
                pc <= taken ? instr[cpu_pkg::imm_hi:cpu_pkg::imm_lo] : pc + 16'd4;
            if (state == EXEC && is_arith) begin
                zf <= (alu_res == '0);
                nf <= alu_res[cpu_pkg::data_w-1];
            end
        end
    end

    // host store request, held through HOST_WAIT
    always_ff @(posedge clk) begin
        if (state == EXEC && to_host) begin
            store_addr <= eff_addr;
            store_data <= rt_data;
        end
    end

    assign fetch_idx   = pc[cpu_pkg::mem_idx_w+1:2];
    assign dm_idx      = eff_addr[cpu_pkg::mem_idx_w+1:2];
    assign dm_wdata    = rt_data;
    assign dm_we       = (state == EXEC) && (op == cpu_pkg::ST) && !to_host;
    assign dm_re       = (state == EXEC) && (op == cpu_pkg::LD);
    assign store_valid = (state == HOST_WAIT);
    assign halted      = (state == HALTED);

    a_store_stable: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid && !store_ready |=> $stable(store_addr) && $stable(store_data));

endmodule

// File: src/cpu_pkg.sv
////////////////////////////////////////////////////////////////////////////
// cpu shared sizes, addresses and encodings
////////////////////////////////////////////////////////////////////////////
package cpu_pkg;

    // widths
    localparam int data_w      = 32;
    localparam int host_addr_w = 32;
    localparam int reg_idx_w   = 4;

    // memory geometry, in 32-bit words
    localparam int mem_words   = 64;
    localparam int mem_idx_w   = 6;

    // host bursts, 64 bytes each
    localparam int burst_words = 16;
    localparam int burst_count = 4;
    localparam int burst_idx_w = $clog2(burst_count);
    localparam int beat_idx_w  = $clog2(burst_words);
    localparam logic [host_addr_w-1:0] burst_bytes = burst_words * 4;

    // address map
    localparam logic [host_addr_w-1:0] im_region     = 32'h0001_0000;
    localparam logic [15:0]            host_win_base = 16'h9000;

    // instruction fields
    localparam int op_hi  = 31;
    localparam int op_lo  = 28;
    localparam int rd_hi  = 27;
    localparam int rd_lo  = 24;
    localparam int rs_hi  = 23;
    localparam int rs_lo  = 20;
    localparam int rt_hi  = 19;
    localparam int rt_lo  = 16;
    localparam int imm_hi = 15;
    localparam int imm_lo = 0;

    typedef enum logic [1:0] {
        HOST_IDLE  = 2'b00,
        HOST_READ  = 2'b01,
        HOST_WRITE = 2'b11
    } host_op_t;

    typedef enum logic [3:0] {
        NOP  = 4'h0,
        ADD  = 4'h1,
        SUB  = 4'h2,
        ADDI = 4'h3,
        LD   = 4'h4,
        ST   = 4'h5,
        BEQ  = 4'h6,
        BNE  = 4'h7,
        BLT  = 4'h8,
        JMP  = 4'h9,
        HALT = 4'hA
    } opcode_t;

endpackage

// File: src/cpu_top.sv
////////////////////////////////////////////////////////////////////////////
// cpu top level
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module cpu_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            host_ready,
    input  logic                            host_rd_valid,
    input  logic [cpu_pkg::data_w-1:0]      host_rd_data,
    input  logic                            host_wr_ready,
    output cpu_pkg::host_op_t               host_op,
    output logic [cpu_pkg::host_addr_w-1:0] host_addr,
    output logic [cpu_pkg::data_w-1:0]      host_wr_data,
    output logic                            halted
);

    // loader to memories
    logic                          load_im_we, load_dm_we;
    logic [cpu_pkg::mem_idx_w-1:0] load_idx;
    logic [cpu_pkg::data_w-1:0]    load_data;

    // core to loader
    logic                          run, store_valid, store_ready;
    logic [15:0]                   store_addr;
    logic [cpu_pkg::data_w-1:0]    store_data;

    // core to memories
    logic [cpu_pkg::mem_idx_w-1:0] fetch_idx, dm_idx;
    logic [cpu_pkg::data_w-1:0]    instr, dm_rdata, dm_wdata;
    logic                          dm_we, dm_re;

    host_loader u_loader (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_ready    (host_ready),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data),
        .store_valid   (store_valid),
        .store_addr    (store_addr),
        .store_data    (store_data),
        .host_wr_ready (host_wr_ready),
        .host_op       (host_op),
        .host_addr     (host_addr),
        .host_wr_data  (host_wr_data),
        .load_im_we    (load_im_we),
        .load_dm_we    (load_dm_we),
        .load_idx      (load_idx),
        .load_data     (load_data),
        .store_ready   (store_ready),
        .run           (run)
    );

    instr_mem u_imem (
        .clk       (clk),
        .load_we   (load_im_we),
        .load_idx  (load_idx),
        .load_data (load_data),
        .fetch_idx (fetch_idx),
        .instr     (instr)
    );

    data_mem u_dmem (
        .clk        (clk),
        .load_we    (load_dm_we),
        .load_idx   (load_idx),
        .load_data  (load_data),
        .core_we    (dm_we),
        .core_re    (dm_re),
        .core_idx   (dm_idx),
        .core_wdata (dm_wdata),
        .core_rdata (dm_rdata)
    );

    cpu_core u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .run         (run),
        .instr       (instr),
        .dm_rdata    (dm_rdata),
        .store_ready (store_ready),
        .fetch_idx   (fetch_idx),
        .dm_we       (dm_we),
        .dm_re       (dm_re),
        .dm_idx      (dm_idx),
        .dm_wdata    (dm_wdata),
        .store_valid (store_valid),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .halted      (halted)
    );

endmodule

// File: src/data_mem.sv
////////////////////////////////////////////////////////////////////////////
// data ram
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module data_mem (
    input  logic                          clk,
    input  logic                          load_we,
    input  logic [cpu_pkg::mem_idx_w-1:0] load_idx,
    input  logic [cpu_pkg::data_w-1:0]    load_data,
    input  logic                          core_we,
    input  logic                          core_re,
    input  logic [cpu_pkg::mem_idx_w-1:0] core_idx,
    input  logic [cpu_pkg::data_w-1:0]    core_wdata,
    output logic [cpu_pkg::data_w-1:0]    core_rdata
);

    logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::mem_words];

    always_ff @(posedge clk) begin
        if (load_we)
            mem[load_idx] <= load_data;
        else if (core_we)
            mem[core_idx] <= core_wdata;
    end

    always_ff @(posedge clk) begin
        if (core_re)
            core_rdata <= mem[core_idx];   // valid the next cycle
    end

    // boot load and core run never overlap
    a_one_writer: assert property (@(posedge clk) !(load_we && core_we));

endmodule

// File: src/host_loader.sv
////////////////////////////////////////////////////////////////////////////
// boot loader and host store bridge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module host_loader (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            host_ready,
    input  logic                            host_rd_valid,
    input  logic [cpu_pkg::data_w-1:0]      host_rd_data,
    input  logic                            store_valid,
    input  logic [15:0]                     store_addr,
    input  logic [cpu_pkg::data_w-1:0]      store_data,
    input  logic                            host_wr_ready,
    output cpu_pkg::host_op_t               host_op,
    output logic [cpu_pkg::host_addr_w-1:0] host_addr,
    output logic [cpu_pkg::data_w-1:0]      host_wr_data,
    output logic                            load_im_we,
    output logic                            load_dm_we,
    output logic [cpu_pkg::mem_idx_w-1:0]   load_idx,
    output logic [cpu_pkg::data_w-1:0]      load_data,
    output logic                            store_ready,
    output logic                            run
);

    typedef enum logic [2:0] {LD_IDLE, LD_DM, LD_IM, LD_GAP, RUNNING} ld_state_t;

    ld_state_t state, next_state;

    logic [cpu_pkg::burst_idx_w-1:0]   burst;
    logic [cpu_pkg::beat_idx_w-1:0]    beat;
    logic                              im_phase;   // set once all dm bursts are in
    logic                              beat_fire;
    logic                              last_beat;
    logic                              last_burst;
    logic [cpu_pkg::host_addr_w-1:0]   burst_base;

    assign beat_fire  = host_rd_valid && (state == LD_DM || state == LD_IM);
    assign last_beat  = (beat == cpu_pkg::beat_idx_w'(cpu_pkg::burst_words - 1));
    assign last_burst = (burst == cpu_pkg::burst_idx_w'(cpu_pkg::burst_count - 1));
    assign burst_base = cpu_pkg::burst_bytes * burst
                      + (im_phase ? cpu_pkg::im_region : '0);

    // counters wrap on their own, both sizes are powers of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= LD_IDLE;
            burst    <= '0;
            beat     <= '0;
            im_phase <= 1'b0;
        end else begin
            state <= next_state;
            if (beat_fire) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    burst <= burst + 1'b1;
                    if (last_burst)
                        im_phase <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            LD_IDLE: if (host_ready) next_state = LD_DM;
            LD_DM, LD_IM: begin
                if (beat_fire && last_beat)
                    next_state = (state == LD_IM && last_burst) ? RUNNING : LD_GAP;
            end
            LD_GAP:  next_state = im_phase ? LD_IM : LD_DM;   // one idle cycle
            default: next_state = RUNNING;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        if (state == LD_DM || state == LD_IM)
            host_op = cpu_pkg::HOST_READ;
        else if (run && store_valid)
            host_op = cpu_pkg::HOST_WRITE;
        else
            host_op = cpu_pkg::HOST_IDLE;
    end

    assign host_addr    = run ? {16'h0, store_addr} : burst_base;
    assign host_wr_data = store_data;
    assign store_ready  = run && host_wr_ready;
    assign run          = (state == RUNNING);

    // memory write strobes, one word per beat
    assign load_dm_we = beat_fire && (state == LD_DM);
    assign load_im_we = beat_fire && (state == LD_IM);
    assign load_idx   = {burst, beat};
    assign load_data  = host_rd_data;

    a_rd_only_in_read: assert property (@(posedge clk) disable iff (!rst_n)
        host_rd_valid |-> host_op == cpu_pkg::HOST_READ);

    a_no_store_before_run: assert property (@(posedge clk) disable iff (!rst_n)
        store_valid |-> run);

endmodule

// File: src/instr_mem.sv
////////////////////////////////////////////////////////////////////////////
// instruction ram
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module instr_mem (
    input  logic                          clk,
    input  logic                          load_we,
    input  logic [cpu_pkg::mem_idx_w-1:0] load_idx,
    input  logic [cpu_pkg::data_w-1:0]    load_data,
    input  logic [cpu_pkg::mem_idx_w-1:0] fetch_idx,
    output logic [cpu_pkg::data_w-1:0]    instr
);

    logic [cpu_pkg::data_w-1:0] mem [cpu_pkg::mem_words];

    // loader wins, fetch port idles while loading
    always_ff @(posedge clk) begin
        if (load_we)
            mem[load_idx] <= load_data;
        else
            instr <= mem[fetch_idx];   // registered fetch
    end

endmodule

// File: src/reg_file.sv
////////////////////////////////////////////////////////////////////////////
// register file
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::reg_idx_w-1:0] rs_sel,
    input  logic [cpu_pkg::reg_idx_w-1:0] rt_sel,
    input  logic [cpu_pkg::reg_idx_w-1:0] wr_sel,
    input  logic                          wr_en,
    input  logic [cpu_pkg::data_w-1:0]    wr_data,
    output logic [cpu_pkg::data_w-1:0]    rs_data,
    output logic [cpu_pkg::data_w-1:0]    rt_data
);

    logic [cpu_pkg::data_w-1:0] regs [2**cpu_pkg::reg_idx_w];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**cpu_pkg::reg_idx_w; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_sel != '0) begin
            regs[wr_sel] <= wr_data;   // r0 stays zero
        end
    end

    assign rs_data = (rs_sel == '0) ? '0 : regs[rs_sel];
    assign rt_data = (rt_sel == '0) ? '0 : regs[rt_sel];

endmodule

// File: include/tb_tasks.svh
////////////////////////////////////////////////////////////////////////////
// program builder, tests and compare tasks
////////////////////////////////////////////////////////////////////////////
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

int test_start_errs;
logic [cpu_pkg::host_addr_w-1:0] exp_addr_q[$];
logic [cpu_pkg::data_w-1:0]      exp_data_q[$];

function automatic logic [cpu_pkg::data_w-1:0] encode(cpu_pkg::opcode_t op,
        int rd, int rs, int rt, int imm);
    logic [cpu_pkg::data_w-1:0] w;
    w = '0;
    w[cpu_pkg::op_hi:cpu_pkg::op_lo]   = op;
    w[cpu_pkg::rd_hi:cpu_pkg::rd_lo]   = 4'(rd);
    w[cpu_pkg::rs_hi:cpu_pkg::rs_lo]   = 4'(rs);
    w[cpu_pkg::rt_hi:cpu_pkg::rt_lo]   = 4'(rt);
    w[cpu_pkg::imm_hi:cpu_pkg::imm_lo] = 16'(imm);
    return w;
endfunction

task automatic emit(input logic [cpu_pkg::data_w-1:0] w);
    im_img[prog_len] = w;
    prog_len++;
endtask

// host store of register src to a window address
task automatic emit_store(input int src, input int addr);
    emit(encode(cpu_pkg::ST, src, 0, 0, addr));
endtask

task automatic expect_write(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
endtask

task automatic check_op(input string name, input cpu_pkg::host_op_t got,
        input cpu_pkg::host_op_t exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_word(input string name, input logic [cpu_pkg::data_w-1:0] got,
        input logic [cpu_pkg::data_w-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_addr(input string name, input logic [cpu_pkg::host_addr_w-1:0] got,
        input logic [cpu_pkg::host_addr_w-1:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %s: got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic start_test();
    test_start_errs = errors;
    prog_len = 0;
    exp_addr_q.delete();
    exp_data_q.delete();
    for (int i = 0; i < cpu_pkg::mem_words; i++) begin
        dm_img[i] = 32'h5A00_0000 + i * 32'h0001_0203;   // pattern per index
        im_img[i] = encode(cpu_pkg::HALT, 0, 0, 0, 0);
    end
endtask

task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_start_errs) begin
        $display("[test] %s passed", name);
    end else begin
        $display("[test] %s failed, %0d errors", name, errors - test_start_errs);
        tests_failed++;
    end
endtask

// 8 cycles of reset with outputs checked in each
task automatic reset_dut();
    @(posedge clk);
    rst_n      <= 1'b0;
    host_ready <= 1'b0;
    repeat (8) begin
        @(negedge clk);
        check_op("host_op", host_op, cpu_pkg::HOST_IDLE);
        check_word("halted", 32'(halted), 32'd0);
        @(posedge clk);
    end
    rst_n <= 1'b1;
    wr_addr_q.delete();
    wr_data_q.delete();
    burst_addr_q.delete();
    burst_beats_q.delete();
    late_halt = 0;
endtask

task automatic load_and_run(input int limit);
    int cnt;
    @(posedge clk);
    host_ready <= 1'b1;
    cnt = 0;
    while (!halted && cnt < limit) begin
        @(posedge clk);
        cnt++;
    end
    if (!halted) begin
        $display("timed out waiting for the core to halt");
        errors++;
    end
    @(posedge clk);
    host_ready <= 1'b0;
endtask

task automatic check_writes();
    if (wr_addr_q.size() != exp_addr_q.size()) begin
        $display("wrong number of host writes: got %0d, expected %0d",
                 wr_addr_q.size(), exp_addr_q.size());
        errors++;
    end
    for (int i = 0; i < wr_addr_q.size() && i < exp_addr_q.size(); i++) begin
        check_addr("host_addr", wr_addr_q[i], exp_addr_q[i]);
        check_word("host_wr_data", wr_data_q[i], exp_data_q[i]);
    end
endtask

////////////////////////////////////////////////////////////////////////////
// directed tests
////////////////////////////////////////////////////////////////////////////
task automatic reset_state_test();
    start_test();
    reset_dut();
    repeat (10) begin   // no host_ready yet
        @(negedge clk);
        check_op("host_op", host_op, cpu_pkg::HOST_IDLE);
        check_word("halted", 32'(halted), 32'd0);
    end
    finish_test("reset state");
endtask

task automatic load_sequence_test();
    logic [31:0] base;
    start_test();
    reset_dut();
    load_and_run(5000);
    if (burst_addr_q.size() != 8) begin
        $display("expected 8 read bursts, saw %0d", burst_addr_q.size());
        errors++;
    end
    for (int b = 0; b < burst_addr_q.size() && b < 8; b++) begin
        base = (b >= 4 ? 32'h0001_0000 : 32'h0) + (b % 4) * 64;
        check_addr("host_addr", burst_addr_q[b], base);
        check_word("burst beats", 32'(burst_beats_q[b]), 32'd16);
    end
    @(negedge clk);
    check_op("host_op", host_op, cpu_pkg::HOST_IDLE);
    finish_test("load sequence");
endtask

task automatic arith_store_test();
    logic [31:0] a;
    logic [31:0] b;
    start_test();
    a = 32'd100;
    b = 32'hFFFF_FFF9;   // -7
    emit(encode(cpu_pkg::ADDI, 1, 0, 0, 100));
    emit(encode(cpu_pkg::ADDI, 2, 0, 0, -7));
    emit(encode(cpu_pkg::ADD, 3, 1, 2, 0));
    emit(encode(cpu_pkg::SUB, 4, 2, 1, 0));
    emit_store(1, 'h9000);
    emit_store(3, 'h9004);
    emit_store(4, 'h9008);
    expect_write(32'h9000, a);
    expect_write(32'h9004, a + b);
    expect_write(32'h9008, b - a);
    reset_dut();
    load_and_run(5000);
    check_writes();
    finish_test("arithmetic and host stores");
endtask

task automatic data_load_test();
    start_test();
    emit(encode(cpu_pkg::LD, 1, 0, 0, 8));
    emit(encode(cpu_pkg::LD, 2, 0, 0, 20));
    emit(encode(cpu_pkg::ADD, 3, 1, 2, 0));
    emit_store(3, 'h9000);
    emit(encode(cpu_pkg::ADDI, 4, 0, 0, 'h1234));
    emit(encode(cpu_pkg::ST, 4, 0, 0, 'h40));   // low address goes to data memory
    emit(encode(cpu_pkg::LD, 5, 0, 0, 'h40));
    emit_store(5, 'h9004);
    expect_write(32'h9000, dm_img[2] + dm_img[5]);
    expect_write(32'h9004, 32'h1234);
    reset_dut();
    load_and_run(5000);
    check_writes();
    finish_test("data loads");
endtask

task automatic branch_test();
    start_test();
    emit(encode(cpu_pkg::ADDI, 1, 0, 0, 5));        // 0
    emit(encode(cpu_pkg::ADDI, 2, 0, 0, 9));        // 4
    emit(encode(cpu_pkg::ADDI, 7, 0, 0, 'hBAD));    // 8  wrong path marker
    emit(encode(cpu_pkg::ADDI, 8, 0, 0, 'h11));     // 12
    emit(encode(cpu_pkg::ADDI, 9, 0, 0, 'h22));     // 16
    emit(encode(cpu_pkg::ADDI, 10, 0, 0, 'h33));    // 20
    emit(encode(cpu_pkg::ADDI, 11, 0, 0, 'h44));    // 24
    emit(encode(cpu_pkg::SUB, 3, 1, 1, 0));         // 28 zero
    emit(encode(cpu_pkg::BNE, 0, 0, 0, 40));        // 32 not taken
    emit_store(8, 'h9000);                          // 36
    emit(encode(cpu_pkg::BEQ, 0, 0, 0, 48));        // 40 taken
    emit_store(7, 'h9000);                          // 44
    emit(encode(cpu_pkg::SUB, 3, 1, 2, 0));         // 48 negative
    emit(encode(cpu_pkg::BLT, 0, 0, 0, 60));        // 52 taken
    emit_store(7, 'h9000);                          // 56
    emit(encode(cpu_pkg::BEQ, 0, 0, 0, 68));        // 60 not taken
    emit_store(9, 'h9000);                          // 64
    emit(encode(cpu_pkg::SUB, 3, 2, 1, 0));         // 68 positive
    emit(encode(cpu_pkg::BLT, 0, 0, 0, 80));        // 72 not taken
    emit_store(10, 'h9000);                         // 76
    emit(encode(cpu_pkg::BNE, 0, 0, 0, 88));        // 80 taken
    emit_store(7, 'h9000);                          // 84
    emit(encode(cpu_pkg::JMP, 0, 0, 0, 96));        // 88
    emit_store(7, 'h9000);                          // 92
    emit_store(11, 'h9000);                         // 96
    expect_write(32'h9000, 32'h11);
    expect_write(32'h9000, 32'h22);
    expect_write(32'h9000, 32'h33);
    expect_write(32'h9000, 32'h44);
    reset_dut();
    load_and_run(5000);
    check_writes();
    finish_test("branches and flags");
endtask

task automatic backpressure_test();
    start_test();
    emit(encode(cpu_pkg::ADDI, 1, 0, 0, 'h100));
    emit_store(1, 'h9000);
    emit(encode(cpu_pkg::ADDI, 1, 1, 0, 1));
    emit_store(1, 'h9004);
    emit(encode(cpu_pkg::ADDI, 1, 1, 0, 1));
    emit_store(1, 'h9008);
    expect_write(32'h9000, 32'h100);
    expect_write(32'h9004, 32'h101);
    expect_write(32'h9008, 32'h102);
    bp_on    = 1'b1;
    hold_len <= 5 + ($unsigned($random(seed)) % 16);
    reset_dut();
    load_and_run(8000);
    check_writes();
    if (late_halt != 0) begin
        $display("halted rose before the last host write completed");
        errors++;
    end
    bp_on    = 1'b0;
    hold_len <= 0;
    finish_test("back-pressure");
endtask

`endif

// File: test/tb_cpu.sv
////////////////////////////////////////////////////////////////////////////
// cpu testbench with host model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_cpu;

    logic                            clk;
    logic                            rst_n;
    logic                            host_ready;
    logic                            host_rd_valid;
    logic [cpu_pkg::data_w-1:0]      host_rd_data;
    logic                            host_wr_ready;
    cpu_pkg::host_op_t               host_op;
    logic [cpu_pkg::host_addr_w-1:0] host_addr;
    logic [cpu_pkg::data_w-1:0]      host_wr_data;
    logic                            halted;

    integer seed = 9;

    // host memory images loaded into the DUT at boot
    logic [cpu_pkg::data_w-1:0] dm_img [cpu_pkg::mem_words];
    logic [cpu_pkg::data_w-1:0] im_img [cpu_pkg::mem_words];
    int prog_len;

    // observed host traffic
    logic [cpu_pkg::host_addr_w-1:0] wr_addr_q[$];
    logic [cpu_pkg::data_w-1:0]      wr_data_q[$];
    logic [cpu_pkg::host_addr_w-1:0] burst_addr_q[$];
    int                              burst_beats_q[$];
    int                              beat_cnt;
    logic                            in_read;
    int                              late_halt;   // writes seen after halted

    // write back-pressure knob
    bit bp_on;
    int hold_len;
    int wait_cnt;

    int errors;
    int tests_run;
    int tests_failed;

    cpu_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .host_ready    (host_ready),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data),
        .host_wr_ready (host_wr_ready),
        .host_op       (host_op),
        .host_addr     (host_addr),
        .host_wr_data  (host_wr_data),
        .halted        (halted)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // host read side with 16 beats per burst and random gaps
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin
        int n;
        logic [cpu_pkg::mem_idx_w-1:0] idx;
        if (!rst_n) begin
            host_rd_valid <= 1'b0;
            beat_cnt      <= 0;
            in_read       <= 1'b0;
        end else if (host_op == cpu_pkg::HOST_READ) begin
            n = (in_read ? beat_cnt : 0) + (host_rd_valid ? 1 : 0);
            if (!in_read)
                burst_addr_q.push_back(host_addr);   // first cycle of a burst
            beat_cnt <= n;
            in_read  <= 1'b1;
            idx = {host_addr[7:6], 4'(n)};
            if (n < cpu_pkg::burst_words && ($random(seed) & 3) != 0) begin
                host_rd_valid <= 1'b1;
                host_rd_data  <= host_addr[16] ? im_img[idx] : dm_img[idx];
            end else begin
                host_rd_valid <= 1'b0;
            end
        end else begin
            if (in_read)
                burst_beats_q.push_back(beat_cnt);
            in_read       <= 1'b0;
            host_rd_valid <= 1'b0;
        end
    end

    // host write side
    always @(posedge clk) begin
        if (!rst_n) begin
            host_wr_ready <= 1'b0;
            wait_cnt      <= 0;
        end else if (host_op == cpu_pkg::HOST_WRITE && host_wr_ready) begin
            wr_addr_q.push_back(host_addr);
            wr_data_q.push_back(host_wr_data);
            if (halted)
                late_halt++;
            host_wr_ready <= 1'b0;
            wait_cnt      <= 0;
            if (bp_on)
                hold_len <= 5 + ($unsigned($random(seed)) % 16);
        end else if (host_op == cpu_pkg::HOST_WRITE) begin
            if (wait_cnt >= hold_len)
                host_wr_ready <= 1'b1;
            else
                wait_cnt <= wait_cnt + 1;
        end else begin
            host_wr_ready <= 1'b0;
        end
    end

    `include "tb_tasks.svh"

    initial begin
        clk           = 1'b0;
        rst_n         <= 1'b0;
        host_ready    <= 1'b0;
        host_rd_valid <= 1'b0;
        host_rd_data  <= '0;
        host_wr_ready <= 1'b0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        bp_on         = 1'b0;
        hold_len      <= 0;

        reset_state_test();
        load_sequence_test();
        arith_store_test();
        data_load_test();
        branch_test();
        backpressure_test();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // overall simulation time limit
    initial begin
        #20_000_000;
        $display("simulation ran past its time limit");
        $display("=== FAIL ===");
        $finish;
    end

endmodule
